// ==== div_controller.sv ====
`timescale 1ns/1ps

module div_controller
(
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic count_16,
    input  logic msb_remainder,
    output logic ack,
    output logic enable,
    output logic select_aq,
    output logic update_quotient
);

    import div_pkg::*;

    ctrl_state_e current_state;
    ctrl_state_e next_state;

    // state register
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            current_state <= IDLE;
        end
        else
        begin
            current_state <= next_state;
        end
    end

    // ack registered off the next state
    // rises on the edge that enters DONE, falls on the edge that leaves it
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= (next_state == DONE);
        end
    end

    // next state and datapath controls
    always_comb
    begin
        next_state      = current_state;
        enable          = 1'b0;
        select_aq       = 1'b0;
        update_quotient = 1'b0;
        case (current_state)
            IDLE:
            begin
                // load edge: a cleared, q and m take the operands
                if (req)
                begin
                    enable     = 1'b1;
                    next_state = PROCESS;
                end
            end
            PROCESS:
            begin
                enable          = 1'b1;
                select_aq       = 1'b1;
                // keep the difference only if the trial subtraction stayed positive
                update_quotient = ~msb_remainder;
                if (count_16)
                begin
                    next_state = DONE;
                end
            end
            DONE:
            begin
                // results frozen while the requester holds req
                if (!req)
                begin
                    next_state = IDLE;
                end
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // four-phase rule, ack holds as long as req does
    assert property (@(posedge clk) disable iff (!reset)
        (ack && req) |=> ack);

    // no datapath or counter activity while ack presents the results
    assert property (@(posedge clk) disable iff (!reset)
        ack |-> !enable);

endmodule

// ==== div_counter.sv ====
`timescale 1ns/1ps

module div_counter
(
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic select_aq,
    output logic count_16
);

    import div_pkg::*;

    logic [COUNT_WIDTH-1:0] count;

    // clear on load, step once per iteration
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            count <= '0;
        end
        else if (enable && !select_aq)
        begin
            count <= '0;
        end
        else if (enable && select_aq && (count != LAST_STEP))
        begin
            count <= count + 1'b1;
        end
    end

    // high during the sixteenth iteration
    assign count_16 = (count == LAST_STEP);

    // controller must stop stepping once the last iteration has run
    assert property (@(posedge clk) disable iff (!reset)
        (enable && select_aq && (count == LAST_STEP)) |=> !(enable && select_aq));

endmodule

// ==== div_datapath.sv ====
`timescale 1ns/1ps

module div_datapath
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  logic                       select_aq,
    input  logic                       update_quotient,
    input  logic [div_pkg::DIV_WIDTH-1:0] dividend,
    input  logic [div_pkg::DIV_WIDTH-1:0] divisor,
    output logic                       msb_remainder,
    output logic [div_pkg::DIV_WIDTH-1:0] quotient,
    output logic [div_pkg::DIV_WIDTH-1:0] remainder
);

    import div_pkg::*;

    // partial remainder, one guard bit for the sign of the trial subtraction
    logic [DIV_WIDTH:0]   a_reg;
    // quotient, starts out holding the dividend
    logic [DIV_WIDTH-1:0] q_reg;
    // divisor
    logic [DIV_WIDTH-1:0] m_reg;

    logic [DIV_WIDTH:0]   shifted_a;
    logic [DIV_WIDTH:0]   diff;

    // {a, q} shifted left by one, msb of q moves into a
    assign shifted_a = {a_reg[DIV_WIDTH-1:0], q_reg[DIV_WIDTH-1]};

    // trial subtraction
    assign diff = shifted_a - {1'b0, m_reg};

    // set when the trial went negative
    assign msb_remainder = diff[DIV_WIDTH];

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            a_reg <= '0;
            q_reg <= '0;
            m_reg <= '0;
        end
        else if (enable)
        begin
            if (!select_aq)
            begin
                // load edge, operands sampled only here
                a_reg <= '0;
                q_reg <= dividend;
                m_reg <= divisor;
            end
            else
            begin
                // keep difference or restore the shifted value
                if (update_quotient)
                begin
                    a_reg <= diff;
                end
                else
                begin
                    a_reg <= shifted_a;
                end
                // new quotient bit enters at the bottom
                q_reg <= {q_reg[DIV_WIDTH-2:0], update_quotient};
            end
        end
    end

    // values held from ack until the next load
    assign quotient  = q_reg;
    assign remainder = a_reg[DIV_WIDTH-1:0];

    // accepting the difference must leave a partial remainder below the divisor
    // m of zero is the divide-by-zero case, skipped
    assert property (@(posedge clk) disable iff (!reset)
        (enable && select_aq && update_quotient && (m_reg != '0))
            |=> (a_reg < {1'b0, m_reg}));

endmodule

// ==== div_pkg.sv ====
package div_pkg;

    // operand, quotient and remainder width
    localparam int unsigned DIV_WIDTH = 16;

    // iteration counter covers steps 0..15
    localparam int unsigned COUNT_WIDTH = 4;

    // counter value during the final iteration
    localparam logic [COUNT_WIDTH-1:0] LAST_STEP = COUNT_WIDTH'(15);

    // controller states
    // DONE holds ack until the requester drops req
    typedef enum logic [1:0]
    {
        IDLE    = 2'b00,
        PROCESS = 2'b01,
        DONE    = 2'b10
    } ctrl_state_e;

endpackage

// ==== divider_top.sv ====
`timescale 1ns/1ps

module divider_top
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,
    input  logic [div_pkg::DIV_WIDTH-1:0] dividend,
    input  logic [div_pkg::DIV_WIDTH-1:0] divisor,
    output logic                       ack,
    output logic [div_pkg::DIV_WIDTH-1:0] quotient,
    output logic [div_pkg::DIV_WIDTH-1:0] remainder
);

    // controller outputs, shared by counter and datapath
    logic enable;
    logic select_aq;
    logic update_quotient;

    // status back to the controller
    logic count_16;
    logic msb_remainder;

    // handshake and sequencing
    div_controller div_controller_i
    (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .count_16        (count_16),
        .msb_remainder   (msb_remainder),
        .ack             (ack),
        .enable          (enable),
        .select_aq       (select_aq),
        .update_quotient (update_quotient)
    );

    // sixteen-step iteration count
    div_counter div_counter_i
    (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .select_aq (select_aq),
        .count_16  (count_16)
    );

    // shift-and-subtract registers
    div_datapath div_datapath_i
    (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .select_aq       (select_aq),
        .update_quotient (update_quotient),
        .dividend        (dividend),
        .divisor         (divisor),
        .msb_remainder   (msb_remainder),
        .quotient        (quotient),
        .remainder       (remainder)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --top-module tb_divider -f vlog.f -o tb_divider_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_divider_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# the log decides pass or fail
if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TB PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi

exit 0

// ==== tb_divider.sv ====
`timescale 1ns/1ps

module tb_divider;

    import div_pkg::*;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int ACK_LATENCY    = 16;
    localparam int RANDOM_RUNS    = 200;

    logic                 clk;
    logic                 reset;
    logic                 req;
    logic [DIV_WIDTH-1:0] dividend;
    logic [DIV_WIDTH-1:0] divisor;
    logic                 ack;
    logic [DIV_WIDTH-1:0] quotient;
    logic [DIV_WIDTH-1:0] remainder;

    integer seed;
    int     error_count;
    int     check_count;

    divider_top divider_top_i
    (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .dividend  (dividend),
        .divisor   (divisor),
        .ack       (ack),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // one compare, one error line on mismatch
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERR %s: actual %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // advance one edge, land 1 ns after it
    // outputs are settled here and inputs change here
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // reference model, divide by zero gives all ones
    function automatic logic [DIV_WIDTH-1:0] model_quotient(input logic [DIV_WIDTH-1:0] dvd,
                                                            input logic [DIV_WIDTH-1:0] dvs);
        model_quotient = (dvs == '0) ? '1 : dvd / dvs;
    endfunction

    // remainder is the dividend itself for a zero divisor
    function automatic logic [DIV_WIDTH-1:0] model_remainder(input logic [DIV_WIDTH-1:0] dvd,
                                                             input logic [DIV_WIDTH-1:0] dvs);
        model_remainder = (dvs == '0) ? dvd : dvd % dvs;
    endfunction

    // nonzero divisor, random shift spreads the quotient range
    task automatic random_operands(output logic [DIV_WIDTH-1:0] dvd,
                                   output logic [DIV_WIDTH-1:0] dvs);
        logic [31:0] rnd;
        logic [31:0] shift_rnd;
        rnd = $random(seed);
        dvd = rnd[DIV_WIDTH-1:0];
        dvs = '0;
        while (dvs == '0)
        begin
            shift_rnd = $random(seed);
            rnd       = $random(seed);
            dvs       = rnd[DIV_WIDTH-1:0] >> shift_rnd[3:0];
        end
    endtask

    // garbage on the operand inputs while the divider runs
    task automatic scramble_operands();
        logic [31:0] rnd;
        rnd      = $random(seed);
        dividend = rnd[DIV_WIDTH-1:0];
        divisor  = rnd[2*DIV_WIDTH-1:DIV_WIDTH];
    endtask

    // full four-phase transaction
    task automatic run_division(input logic [DIV_WIDTH-1:0] dvd,
                                input logic [DIV_WIDTH-1:0] dvs,
                                input int hold_cycles,
                                input bit scramble);
        logic [DIV_WIDTH-1:0] exp_q;
        logic [DIV_WIDTH-1:0] exp_r;
        int                   edges;
        exp_q    = model_quotient(dvd, dvs);
        exp_r    = model_remainder(dvd, dvs);
        // request with operands stable
        dividend = dvd;
        divisor  = dvs;
        req      = 1'b1;
        // E0, load edge
        next_cycle();
        check_value("ack", 32'(ack), 32'h0);
        edges = 0;
        while (!ack && edges < TIMEOUT_CYCLES)
        begin
            // operands only matter at E0
            if (scramble)
            begin
                scramble_operands();
            end
            next_cycle();
            edges++;
        end
        if (!ack)
        begin
            error_count++;
            $display("timeout: ack did not rise within %0d cycles of req", TIMEOUT_CYCLES);
        end
        else
        begin
            check_value("ack_latency", 32'(edges), 32'(ACK_LATENCY));
            check_value("quotient", 32'(quotient), 32'(exp_q));
            check_value("remainder", 32'(remainder), 32'(exp_r));
            // requester lingers, results frozen
            repeat (hold_cycles)
            begin
                next_cycle();
                check_value("ack", 32'(ack), 32'h1);
                check_value("quotient", 32'(quotient), 32'(exp_q));
                check_value("remainder", 32'(remainder), 32'(exp_r));
            end
        end
        // release phase
        req   = 1'b0;
        edges = 0;
        while (ack && edges < TIMEOUT_CYCLES)
        begin
            next_cycle();
            edges++;
        end
        if (ack)
        begin
            error_count++;
            $display("timeout: ack stayed high %0d cycles after req fell", TIMEOUT_CYCLES);
        end
    endtask

    initial
    begin
        logic [DIV_WIDTH-1:0] dvd;
        logic [DIV_WIDTH-1:0] dvs;
        logic [31:0]          rnd;
        int                   i;
        seed        = 32'h3d60;
        error_count = 0;
        check_count = 0;
        clk         = 1'b0;
        reset       = 1'b0;
        req         = 1'b0;
        dividend    = '0;
        divisor     = '0;

        // two cycles of reset
        repeat (2) next_cycle();
        reset = 1'b1;
        check_value("ack", 32'(ack), 32'h0);
        next_cycle();
        check_value("ack", 32'(ack), 32'h0);

        // corner cases
        // zero divisor, quotient all ones
        run_division(16'h1234, 16'h0000, 0, 1'b0);
        // divisor above dividend, quotient zero
        run_division(16'h0064, 16'h03e8, 1, 1'b0);
        rnd = $random(seed);
        // divide by one
        run_division(rnd[DIV_WIDTH-1:0], 16'h0001, 0, 1'b0);
        // zero dividend
        run_division(16'h0000, 16'h00ff, 0, 1'b0);
        // both at max
        run_division(16'hffff, 16'hffff, 2, 1'b0);
        run_division(16'hffff, 16'h0001, 0, 1'b0);

        // random operands, random hold, inputs scrambled mid-run
        for (i = 0; i < RANDOM_RUNS; i++)
        begin
            random_operands(dvd, dvs);
            rnd = $random(seed);
            run_division(dvd, dvs, int'(rnd[2:0]), 1'b1);
        end

        // reset in the middle of a division
        random_operands(dvd, dvs);
        dividend = dvd;
        divisor  = dvs;
        req      = 1'b1;
        repeat (6) next_cycle();
        check_value("ack", 32'(ack), 32'h0);
        reset = 1'b0;
        #1;
        check_value("ack", 32'(ack), 32'h0);
        // req still high, a division that kept running would be presenting ack by now
        repeat (12) next_cycle();
        check_value("ack", 32'(ack), 32'h0);
        req   = 1'b0;
        reset = 1'b1;
        next_cycle();
        check_value("ack", 32'(ack), 32'h0);
        // same operands again, from a clean start
        run_division(dvd, dvs, 2, 1'b0);

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
div_pkg.sv
div_controller.sv
div_counter.sv
div_datapath.sv
divider_top.sv
tb_divider.sv
